/* memBox.f */
+incdir+rtl
rtl/memBoxPkg.sv
rtl/storePortIf.sv
rtl/phaseSequencer.sv
rtl/wordCounter.sv
rtl/coreStore.sv
rtl/memBox.sv
test/memBoxChecker.sv
test/memBoxTb.sv

/* rtl/coreStore.sv */
// Core word array for the quadword memory box
// Combinational read with odd parity, parity-checked synchronous write
`timescale 1ns/10ps
`include "memBox_config.svh"

module coreStore
  import memBoxPkg::*;
(
  input  logic      clk,
  input  logic      reset,
  output logic      parityError,  // Sticky until reset
  storePortIf.store storePort
);

  word36 mem [`MEM_WORDS];
  logic  wrParOk;  // Data plus parity bit has an odd count of ones

  // Read path, zero when no read slot is active
  assign storePort.rdData = storePort.readEn ? mem[storePort.wordAddr] : '0;

  // Odd parity generator on read
  assign storePort.rdPar = ~^storePort.rdData;

  // Parity check on incoming write data
  assign wrParOk = ^{storePort.wrData, storePort.wrPar};

  // Bad words are dropped and the old contents stay
  always_ff @(posedge clk) begin
    if (storePort.writeEn && wrParOk) begin
      mem[storePort.wordAddr] <= storePort.wrData;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      parityError <= 1'b0;
    end else if (storePort.writeEn && !wrParOk) begin
      parityError <= 1'b1;  // Visible from the next cycle
    end
  end

  // Sequencer strobes come from one latched read/write flag
  assert property (@(posedge clk) disable iff (reset)
                   !(storePort.readEn && storePort.writeEn))
    else $error("read and write strobes both high");

endmodule

/* rtl/memBox.sv */
// Quadword core memory box on a 36-bit memory bus
// Joins the bus sequencer, word counter and core store
`timescale 1ns/10ps
`include "memBox_config.svh"

module memBox
  import memBoxPkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  input  logic [`BUS_ADDR_BITS-1:0] adr,
  input  slotMask                   rq,
  input  logic                      write,
  input  word36                     dOut,      // Write data from controller
  input  logic                      parOut,
  input  logic                      outValid,
  output logic                      ackn,
  output logic                      inValid,
  output word36                     dIn,       // Read data to controller
  output logic                      parIn,
  output logic                      parityError
);

  logic load;       // Sequencer accepts a cycle
  logic step;
  logic slotHit;
  logic maskEmpty;

  storePortIf storeBus ();

  phaseSequencer sequencer (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .write     (write),
    .outValid  (outValid),
    .dOut      (dOut),
    .parOut    (parOut),
    .slotHit   (slotHit),
    .maskEmpty (maskEmpty),
    .load      (load),
    .step      (step),
    .ackn      (ackn),
    .inValid   (inValid),
    .dIn       (dIn),
    .parIn     (parIn),
    .storePort (storeBus.seq)
  );

  // Address and slot tracking
  wordCounter counter (
    .clk       (clk),
    .reset     (reset),
    .load      (load),
    .step      (step),
    .adr       (adr),
    .rq        (rq),
    .slotHit   (slotHit),
    .maskEmpty (maskEmpty),
    .storePort (storeBus.seq)
  );

  coreStore store (
    .clk         (clk),
    .reset       (reset),
    .parityError (parityError),
    .storePort   (storeBus.store)
  );

endmodule

/* rtl/memBoxPkg.sv */
// Shared types for the quadword memory box
// Word, request mask and sequencer state
package memBoxPkg;

  // One 36-bit memory word, parity travels beside it
  typedef logic [35:0] word36;

  // Word request mask for the four quadword slots
  // Bit 0 is the first slot after acceptance
  typedef logic [3:0] slotMask;

  // Bus sequencer states
  typedef enum logic {
    IDLE = 1'b0,  // Waiting for start
    BUSY = 1'b1   // Stepping through slots
  } seqState;

endpackage

/* rtl/memBox_config.svh */
// Sizing macros for the quadword core memory box
// Store depth and bus address width shared by RTL and testbench
`ifndef MEMBOX_CONFIG_SVH
`define MEMBOX_CONFIG_SVH

// Address bits that index the core store
`define MEM_ADDR_BITS 12

// Words in the core store
`define MEM_WORDS (1 << `MEM_ADDR_BITS)

// Bus address width, upper bits above MEM_ADDR_BITS alias
`define BUS_ADDR_BITS 22

`endif

/* rtl/phaseSequencer.sv */
// Bus sequencer for the quadword memory box
// Accepts start when idle, then paces one word slot per clock
`timescale 1ns/10ps

module phaseSequencer
  import memBoxPkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    start,
  input  logic    write,
  input  logic    outValid,
  input  word36   dOut,
  input  logic    parOut,
  input  logic    slotHit,    // Current slot was requested
  input  logic    maskEmpty,  // No requested slot left after this edge
  output logic    load,
  output logic    step,
  output logic    ackn,
  output logic    inValid,
  output word36   dIn,
  output logic    parIn,
  storePortIf.seq storePort
);

  seqState state;
  logic    writeCycle;  // Read/write flag captured at acceptance

  // Accept only from IDLE, start is ignored while BUSY
  assign load = (state == IDLE) && start;

  // Advance offset and mask once per slot
  assign step = (state == BUSY);

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= IDLE;
      writeCycle <= 1'b0;
    end else begin
      if (load) begin
        writeCycle <= write;
      end
      case (state)
        IDLE: begin
          // Empty rq is accepted but never leaves IDLE
          if (load && !maskEmpty) begin
            state <= BUSY;
          end
        end
        BUSY: begin
          if (maskEmpty) begin
            state <= IDLE;  // Trailing zero bits take no cycles
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Mask is drained while IDLE, so the slot bit alone marks a hit
  assign ackn    = slotHit;
  assign inValid = slotHit && !writeCycle;  // Read data rides with ackn

  // Store strobes for the hit slot
  assign storePort.readEn  = inValid;
  assign storePort.writeEn = slotHit && writeCycle && outValid;
  assign storePort.wrData  = dOut;  // Controller drives data in the ackn cycle
  assign storePort.wrPar   = parOut;

  // Bus data is zero outside valid read slots
  assign dIn   = inValid ? storePort.rdData : '0;
  assign parIn = inValid ? storePort.rdPar : 1'b0;

  // The word counter mask must be empty whenever the sequencer is idle
  assert property (@(posedge clk) disable iff (reset) ackn |-> (state == BUSY))
    else $error("ackn raised while sequencer is idle");

endmodule

/* rtl/storePortIf.sv */
// Store port between the bus sequencer side and the core word array
// Carries one word address, read and write strobes, and both data paths
`timescale 1ns/10ps
`include "memBox_config.svh"

interface storePortIf
  import memBoxPkg::*;
();

  logic [`MEM_ADDR_BITS-1:0] wordAddr;  // Word index, driven by the word counter
  logic                      readEn;    // Read slot in progress
  logic                      writeEn;   // Write slot with valid data
  word36                     wrData;
  logic                      wrPar;     // Parity as sent by the controller
  word36                     rdData;    // Zero when readEn is low
  logic                      rdPar;     // Odd parity over rdData

  // Sequencer and word counter side
  modport seq (
    output wordAddr,
    output readEn,
    output writeEn,
    output wrData,
    output wrPar,
    input  rdData,
    input  rdPar
  );

  // Core store side
  modport store (
    input  wordAddr,
    input  readEn,
    input  writeEn,
    input  wrData,
    input  wrPar,
    output rdData,
    output rdPar
  );

endinterface

/* rtl/wordCounter.sv */
// Word counter for the quadword memory box
// Holds quadword base, wrapping word offset and remaining request mask
`timescale 1ns/10ps
`include "memBox_config.svh"

module wordCounter
  import memBoxPkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      load,       // Cycle accepted
  input  logic                      step,       // One slot done
  input  logic [`BUS_ADDR_BITS-1:0] adr,
  input  slotMask                   rq,
  output logic                      slotHit,
  output logic                      maskEmpty,
  storePortIf.seq                   storePort   // Drives wordAddr only
);

  logic [`MEM_ADDR_BITS-1:2] base;           // Quadword base, upper bus bits alias
  logic [1:0]                offset;         // Word offset, wraps mod 4
  slotMask                   remaining;      // Slots not yet passed
  slotMask                   nextRemaining;

  // Mask after the coming edge
  always_comb begin
    nextRemaining = remaining;
    if (load) begin
      nextRemaining = rq;
    end else if (step) begin
      nextRemaining = remaining >> 1;  // Next slot moves into bit 0
    end
  end

  assign maskEmpty = (nextRemaining == '0);
  assign slotHit   = remaining[0];

  // Low two bits replaced by the wrapping offset
  assign storePort.wordAddr = {base, offset};

  always_ff @(posedge clk) begin
    if (reset) begin
      remaining <= '0;
      offset    <= 2'd0;
    end else begin
      remaining <= nextRemaining;
      if (load) begin
        offset <= adr[1:0];  // Start word within the quadword
      end else if (step) begin
        offset <= offset + 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      base <= adr[`MEM_ADDR_BITS-1:2];
    end
  end

  // Sequencer must leave BUSY once the mask drains
  assert property (@(posedge clk) disable iff (reset) step |-> (remaining != '0))
    else $error("step issued with an empty request mask");
  assert property (@(posedge clk) disable iff (reset) load |-> (remaining == '0))
    else $error("request mask reloaded while slots remain");

endmodule

/* run.sh */
#!/bin/bash
# Build the memory box testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module memBoxTb -Mdir obj_dir -f memBox.f || exit 1

simOutput=$(./obj_dir/VmemBoxTb)
echo "$simOutput"
echo "$simOutput" | grep -q "^Simulation passed$" && exit 0 || exit 1

/* test/memBoxChecker.sv */
// Bus checker for the quadword memory box
// Counts slots from the accepting edge and compares the bus against a model store
`timescale 1ns/10ps
`include "memBox_config.svh"

module memBoxChecker
  import memBoxPkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  input  logic [`BUS_ADDR_BITS-1:0] adr,
  input  slotMask                   rq,
  input  logic                      write,
  input  word36                     dOut,
  input  logic                      parOut,
  input  logic                      outValid,
  input  logic                      ackn,
  input  logic                      inValid,
  input  word36                     dIn,
  input  logic                      parIn,
  input  logic                      parityError,
  output int                        errorCount
);

  word36                     model [int];        // Good-parity words by store index
  logic                      busy = 1'b0;
  logic [1:0]                slot;               // Slot index within the accepted cycle
  logic [`MEM_ADDR_BITS-1:0] cycAdr;             // Accepted address, upper bits dropped
  slotMask                   cycRq;
  logic                      cycWrite;
  logic                      parErrExp = 1'b0;   // Sticky flag as the bus should show it
  int                        errors = 0;

  assign errorCount = errors;

  // Bit that makes the ones count of word plus bit odd
  function automatic logic oddParity(word36 w);
    return ~^w;
  endfunction

  // Low two address bits advance by the slot and wrap inside the quadword
  function automatic int wordIndex(logic [`MEM_ADDR_BITS-1:0] base, logic [1:0] s);
    logic [1:0] off;
    off = base[1:0] + s;
    return int'({base[`MEM_ADDR_BITS-1:2], off});
  endfunction

  task automatic reportMismatch(string name, word36 expVal, word36 gotVal);
    errors++;
    $display("MISMATCH %s expected %h got %h at %0t", name, expVal, gotVal, $time);
  endtask

  task automatic reportFailure(string what);
    errors++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  // Mid-cycle sampling, inputs settle 2 ns after the edge
  always @(negedge clk) begin
    int   idx;
    logic expAck;
    logic parErrNext;
    parErrNext = 1'b0;
    if (reset) begin
      busy      = 1'b0;
      parErrExp = 1'b0;
    end else begin
      if (parityError !== parErrExp) begin
        reportMismatch("parityError", 36'(parErrExp), 36'(parityError));
      end
      if (busy) begin
        expAck = cycRq[slot];  // Slot i answers rq bit i
        idx    = wordIndex(cycAdr, slot);
        if (expAck && ackn !== 1'b1) begin
          reportFailure($sformatf("ackn missing in slot %0d", slot));
        end else if (!expAck && ackn !== 1'b0) begin
          reportFailure($sformatf("unexpected ackn in unrequested slot %0d", slot));
        end
        if (!cycWrite) begin
          if (inValid !== expAck) reportMismatch("inValid", 36'(expAck), 36'(inValid));
          if (!expAck) begin
            if (dIn !== '0) reportMismatch("dIn", '0, dIn);  // Clear slot reads zero
          end else if (!model.exists(idx)) begin
            reportFailure($sformatf("read of store word %h that was never written", idx));
          end else begin
            if (dIn !== model[idx]) reportMismatch("dIn", model[idx], dIn);
            if (parIn !== oddParity(model[idx])) begin
              reportMismatch("parIn", 36'(oddParity(model[idx])), 36'(parIn));
            end
          end
        end else begin
          if (inValid !== 1'b0) reportMismatch("inValid", '0, 36'(inValid));
          if (dIn !== '0) reportMismatch("dIn", '0, dIn);
          // Word lands at the end of its ackn cycle
          if (expAck && outValid) begin
            if (^{dOut, parOut}) begin
              model[idx] = dOut;
            end else begin
              parErrNext = 1'b1;  // Dropped, flag rises next cycle
            end
          end
        end
        // Trailing clear bits take no cycles
        if (((cycRq >> slot) >> 1) == 4'b0) begin
          busy = 1'b0;
        end else begin
          slot = slot + 2'd1;
        end
      end else begin
        if (ackn !== 1'b0) reportFailure("unexpected ackn while idle");
        if (inValid !== 1'b0) reportMismatch("inValid", '0, 36'(inValid));
        if (dIn !== '0) reportMismatch("dIn", '0, dIn);
        if (start) begin
          cycAdr   = adr[`MEM_ADDR_BITS-1:0];  // Bits above the store alias
          cycRq    = rq;
          cycWrite = write;
          slot     = 2'd0;
          busy     = (rq != 4'b0);  // Empty mask accepted with no slots
        end
      end
      parErrExp = parErrExp | parErrNext;
    end
  end

endmodule

/* test/memBoxTb.sv */
// Testbench for the quadword memory box
// Applies a table of bus cycles and reports the checker's error count
`timescale 1ns/10ps
`include "memBox_config.svh"

module memBoxTb
  import memBoxPkg::*;
();

  // One bus cycle with the acked slot range it should produce
  typedef struct {
    logic                      wr;
    logic [`BUS_ADDR_BITS-1:0] adr;
    slotMask                   rq;
    word36                     seed;      // Slot i writes seed + i
    logic                      badPar;    // Even parity on every write slot
    logic                      hold;      // Start stays high through the cycle
    int                        firstAck;  // -1 for an empty mask
    int                        lastAck;
  } busRow;

  logic                      clk;
  logic                      reset;
  logic                      start;
  logic [`BUS_ADDR_BITS-1:0] adr;
  slotMask                   rq;
  logic                      write;
  word36                     dOut;
  logic                      parOut;
  logic                      outValid;
  logic                      ackn;
  logic                      inValid;
  word36                     dIn;
  logic                      parIn;
  logic                      parityError;

  busRow rows[$];
  int    resetRow;          // Row that follows a reset pulse
  int    timeouts = 0;
  logic  timedOut = 1'b0;
  int    checkErrors;

  memBox uut (
    .clk(clk), .reset(reset), .start(start), .adr(adr), .rq(rq), .write(write),
    .dOut(dOut), .parOut(parOut), .outValid(outValid), .ackn(ackn),
    .inValid(inValid), .dIn(dIn), .parIn(parIn), .parityError(parityError)
  );

  memBoxChecker check (
    .clk(clk), .reset(reset), .start(start), .adr(adr), .rq(rq), .write(write),
    .dOut(dOut), .parOut(parOut), .outValid(outValid), .ackn(ackn),
    .inValid(inValid), .dIn(dIn), .parIn(parIn), .parityError(parityError),
    .errorCount(checkErrors)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic int lowestSet(slotMask m);
    int pos;
    pos = -1;
    for (int i = 0; i < 4; i++) begin
      if (m[0] && pos < 0) pos = i;
      m = m >> 1;
    end
    return pos;
  endfunction

  function automatic int highestSet(slotMask m);
    int pos;
    pos = -1;
    for (int i = 0; i < 4; i++) begin
      if (m[0]) pos = i;
      m = m >> 1;
    end
    return pos;
  endfunction

  function automatic void addRow(logic wr, logic [`BUS_ADDR_BITS-1:0] a, slotMask m,
                                 word36 seed, logic badPar, logic hold, int first, int last);
    busRow row;
    row = '{wr, a, m, seed, badPar, hold, first, last};
    rows.push_back(row);
  endfunction

  task automatic buildRows();
    logic [31:0]               r;
    logic [31:0]               lowWord;
    logic [`BUS_ADDR_BITS-1:0] a;
    slotMask                   m;
    // Fill three quadwords, then read them back at every offset
    addRow(1'b1, 22'h000040, 4'b1111, 36'h1_2345_6700, 1'b0, 1'b0, 0, 3);
    addRow(1'b0, 22'h000040, 4'b1111, '0, 1'b0, 1'b0, 0, 3);
    addRow(1'b1, 22'h000100, 4'b1111, 36'h8_0000_0010, 1'b0, 1'b0, 0, 3);
    addRow(1'b1, 22'h000ffc, 4'b1111, 36'hf_ffff_fff0, 1'b0, 1'b0, 0, 3);
    addRow(1'b0, 22'h000101, 4'b1111, '0, 1'b0, 1'b0, 0, 3);  // Wraps after word 3
    addRow(1'b0, 22'h000102, 4'b0101, '0, 1'b0, 1'b0, 0, 2);
    addRow(1'b0, 22'h000fff, 4'b1111, '0, 1'b0, 1'b0, 0, 3);
    addRow(1'b0, 22'h000042, 4'b0010, '0, 1'b0, 1'b0, 1, 1);  // Ends early
    addRow(1'b0, 22'h000040, 4'b0000, '0, 1'b0, 1'b0, -1, -1);
    addRow(1'b1, 22'h000041, 4'b0001, 36'h5_5555_5555, 1'b1, 1'b0, 0, 0);
    addRow(1'b0, 22'h000040, 4'b1111, '0, 1'b0, 1'b0, 0, 3);  // Old word still there
    // Back to back with start held, plus aliased addresses
    addRow(1'b1, 22'h000103, 4'b1000, 36'h0_0bad_f00d, 1'b0, 1'b1, 3, 3);
    addRow(1'b0, 22'h000100, 4'b0011, '0, 1'b0, 1'b1, 0, 1);
    addRow(1'b0, 22'h2a5040, 4'b1111, '0, 1'b0, 1'b1, 0, 3);
    addRow(1'b1, 22'h1ff100, 4'b0011, 36'h3_1415_9260, 1'b0, 1'b0, 0, 1);
    addRow(1'b0, 22'h000100, 4'b1111, '0, 1'b0, 1'b0, 0, 3);
    // Random cycles inside the filled quadwords
    for (int i = 0; i < 16; i++) begin
      r       = $urandom;
      lowWord = $urandom;
      case (r[16:15])
        2'd0:    a = 22'h000040;
        2'd1:    a = 22'h000100;
        default: a = 22'h000ffc;
      endcase
      a[`BUS_ADDR_BITS-1:`MEM_ADDR_BITS] = r[`BUS_ADDR_BITS-`MEM_ADDR_BITS+16:17];
      a[1:0] = r[1:0];
      m      = r[5:2];
      addRow(r[6], a, m, {r[14:11], lowWord}, r[9:7] == 3'd0, r[10],
             lowestSet(m), highestSet(m));
    end
    resetRow = rows.size();
    addRow(1'b0, 22'h000040, 4'b1111, '0, 1'b0, 1'b0, 0, 3);  // Store survives reset
  endtask

  // Write data for an acked slot, idle values otherwise
  task automatic answerSlot(input busRow r, input int s);
    word36 data;
    if (r.wr && ackn) begin
      data     = r.seed + 36'(s);
      dOut     = data;
      parOut   = r.badPar ? ^data : ~^data;
      outValid = 1'b1;
    end else begin
      dOut     = '0;
      parOut   = 1'b0;
      outValid = 1'b0;
    end
  endtask

  task automatic runRow(input busRow r, input int rowNum);
    int waitCount;
    start    = 1'b1;
    adr      = r.adr;
    rq       = r.rq;
    write    = r.wr;
    outValid = 1'b0;
    if (r.firstAck < 0) begin
      @(posedge clk);  // Accepted here, no slots follow
      #2;
      start = 1'b0;
    end else begin
      waitCount = 0;
      do begin
        @(posedge clk);
        #2;
        waitCount++;
      end while (!ackn && waitCount < 20);
      if (!ackn) begin
        timedOut = 1'b1;
        timeouts++;
        $display("Timeout: no ackn within 20 cycles on row %0d", rowNum);
      end else begin
        if (!r.hold) start = 1'b0;
        for (int s = r.firstAck; s <= r.lastAck; s++) begin
          if (s != r.firstAck) begin
            @(posedge clk);
            #2;
          end
          answerSlot(r, s);
        end
        @(posedge clk);  // Idle cycle after the final slot
        #2;
        answerSlot(r, -1);
      end
    end
  endtask

  task automatic pulseReset();
    start = 1'b0;
    reset = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
  endtask

  initial begin
    int unsigned seedEcho;
    seedEcho = $urandom(32'h7b16_e121);
    reset    = 1'b1;
    start    = 1'b0;
    adr      = '0;
    rq       = '0;
    write    = 1'b0;
    dOut     = '0;
    parOut   = 1'b0;
    outValid = 1'b0;
    buildRows();
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
    for (int i = 0; i < rows.size() && !timedOut; i++) begin
      if (i == resetRow) pulseReset();
      runRow(rows[i], i);
    end
    start = 1'b0;
    repeat (4) @(posedge clk);
    $display("Run done with seed %h: %0d checker errors, %0d timeouts",
             seedEcho, checkErrors, timeouts);
    if (checkErrors == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
